//--- pid_pkg.sv
`default_nettype none

package pid_pkg;

	////////////////////////////////////////
	// datapath widths and types
	////////////////////////////////////////

	// adc sample
	localparam int W_ADC = 18;
	typedef logic signed [W_ADC-1:0] adc_t;

	// pid output word and coefficients
	localparam int W_PID = 16;
	typedef logic signed [W_PID-1:0] pid_t;
	localparam int W_COEF = 16;
	typedef logic signed [W_COEF-1:0] coef_t;
	localparam int PID_SHIFT = 8;

	// integrator, saturates at signed 32 bit limits
	localparam int W_INT = 32;
	localparam logic signed [W_INT-1:0] INT_MAX = {1'b0, {(W_INT-1){1'b1}}};
	localparam logic signed [W_INT-1:0] INT_MIN = {1'b1, {(W_INT-1){1'b0}}};
	localparam pid_t PID_MAX = {1'b0, {(W_PID-1){1'b1}}};
	localparam pid_t PID_MIN = {1'b1, {(W_PID-1){1'b0}}};

	// oversample ratio, log2 of the block length
	localparam int W_ORT = 3;
	typedef logic [W_ORT-1:0] log_ovr_t;
	localparam int MAX_LOG_OVR = 4;

	// output stage
	localparam int W_BOUND = 48;
	typedef logic signed [W_BOUND-1:0] bound_t;
	localparam int W_MULT = 8;
	typedef logic [W_MULT-1:0] mult_t;
	typedef logic [15:0] dac_word_t;
	typedef logic [47:0] freq_word_t;

	////////////////////////////////////////
	// host register map
	////////////////////////////////////////

	typedef logic [7:0] cfg_addr_t;
	typedef logic [31:0] cfg_data_t;

	localparam cfg_addr_t ADDR_LOG_OVR   = 8'h00;
	localparam cfg_addr_t ADDR_ACTIVATE  = 8'h01;
	localparam cfg_addr_t ADDR_SETPOINT  = 8'h02;
	localparam cfg_addr_t ADDR_P_COEF    = 8'h03;
	localparam cfg_addr_t ADDR_I_COEF    = 8'h04;
	localparam cfg_addr_t ADDR_D_COEF    = 8'h05;
	localparam cfg_addr_t ADDR_PID_CLEAR = 8'h06;
	localparam cfg_addr_t ADDR_LOCK_EN   = 8'h07;
	localparam cfg_addr_t ADDR_INIT_EN   = 8'h08;
	localparam cfg_addr_t ADDR_MULT      = 8'h09;
	// 48 bit bounds are split, lo holds bits 31:0, hi holds 47:32
	localparam cfg_addr_t ADDR_MIN_LO    = 8'h0a;
	localparam cfg_addr_t ADDR_MIN_HI    = 8'h0b;
	localparam cfg_addr_t ADDR_MAX_LO    = 8'h0c;
	localparam cfg_addr_t ADDR_MAX_HI    = 8'h0d;
	localparam cfg_addr_t ADDR_INIT_LO   = 8'h0e;
	localparam cfg_addr_t ADDR_INIT_HI   = 8'h0f;
	// one source select per output from here up
	localparam cfg_addr_t ADDR_SRC_BASE  = 8'h10;

endpackage

`default_nettype wire

//--- config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module config_regs import pid_pkg::*; #(
	parameter int N_CHAN = 4,
	parameter int N_OUT = 3,
	localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
	input  logic              clk50,
	input  logic              reset,
	input  logic              cfg_write,
	input  cfg_addr_t         cfg_addr,
	input  cfg_data_t         cfg_data,
	input  logic              cfg_update,
	output log_ovr_t          log_ovr,
	output logic [N_CHAN-1:0] activate,
	output logic [N_CHAN-1:0] pid_clear,
	output coef_t             setpoint,
	output coef_t             p_coef,
	output coef_t             i_coef,
	output coef_t             d_coef,
	output logic [W_CHAN-1:0] src_sel [N_OUT],
	output logic [N_OUT-1:0]  lock_en,
	output logic [N_OUT-1:0]  init_en,
	output bound_t            out_min,
	output bound_t            out_max,
	output bound_t            out_init,
	output mult_t             multiplier
);

////////////////////////////////////////
// staging copy written by the host
////////////////////////////////////////

log_ovr_t          stg_log_ovr;
logic [N_CHAN-1:0] stg_activate;
logic [N_CHAN-1:0] stg_pid_clear;
coef_t             stg_setpoint;
coef_t             stg_p_coef;
coef_t             stg_i_coef;
coef_t             stg_d_coef;
logic [W_CHAN-1:0] stg_src [N_OUT];
logic [N_OUT-1:0]  stg_lock_en;
logic [N_OUT-1:0]  stg_init_en;
bound_t            stg_min;
bound_t            stg_max;
bound_t            stg_init;
mult_t             stg_mult;

always_ff @(posedge clk50) begin
	if (reset) begin
		stg_log_ovr <= '0;
		stg_activate <= '0;
		stg_pid_clear <= '0;
		stg_setpoint <= '0;
		stg_p_coef <= '0;
		stg_i_coef <= '0;
		stg_d_coef <= '0;
		stg_src <= '{default: '0};
		stg_lock_en <= '0;
		stg_init_en <= '0;
		stg_min <= '0;
		stg_max <= '0;
		stg_init <= '0;
		stg_mult <= '0;
	end else if (cfg_write) begin
		case (cfg_addr)
			ADDR_LOG_OVR:   stg_log_ovr <= cfg_data[W_ORT-1:0];
			ADDR_ACTIVATE:  stg_activate <= cfg_data[N_CHAN-1:0];
			ADDR_SETPOINT:  stg_setpoint <= cfg_data[W_COEF-1:0];
			ADDR_P_COEF:    stg_p_coef <= cfg_data[W_COEF-1:0];
			ADDR_I_COEF:    stg_i_coef <= cfg_data[W_COEF-1:0];
			ADDR_D_COEF:    stg_d_coef <= cfg_data[W_COEF-1:0];
			ADDR_PID_CLEAR: stg_pid_clear <= cfg_data[N_CHAN-1:0];
			ADDR_LOCK_EN:   stg_lock_en <= cfg_data[N_OUT-1:0];
			ADDR_INIT_EN:   stg_init_en <= cfg_data[N_OUT-1:0];
			ADDR_MULT:      stg_mult <= cfg_data[W_MULT-1:0];
			ADDR_MIN_LO:    stg_min[31:0] <= cfg_data;
			ADDR_MIN_HI:    stg_min[W_BOUND-1:32] <= cfg_data[W_BOUND-33:0];
			ADDR_MAX_LO:    stg_max[31:0] <= cfg_data;
			ADDR_MAX_HI:    stg_max[W_BOUND-1:32] <= cfg_data[W_BOUND-33:0];
			ADDR_INIT_LO:   stg_init[31:0] <= cfg_data;
			ADDR_INIT_HI:   stg_init[W_BOUND-1:32] <= cfg_data[W_BOUND-33:0];
			default: begin
				// source selects sit above the fixed map and other addresses are ignored
				for (int o = 0; o < N_OUT; o++) begin
					if (cfg_addr == cfg_addr_t'(ADDR_SRC_BASE + o))
						stg_src[o] <= cfg_data[W_CHAN-1:0];
				end
			end
		endcase
	end
end

////////////////////////////////////////
// active set committed on update
////////////////////////////////////////

always_ff @(posedge clk50) begin
	if (reset) begin
		log_ovr <= '0;
		activate <= '0;
		pid_clear <= '0;
		setpoint <= '0;
		p_coef <= '0;
		i_coef <= '0;
		d_coef <= '0;
		src_sel <= '{default: '0};
		lock_en <= '0;
		init_en <= '0;
		out_min <= '0;
		out_max <= '0;
		out_init <= '0;
		multiplier <= '0;
	end else begin
		// masks are single cycle pulses
		pid_clear <= '0;
		init_en <= '0;
		if (cfg_update) begin
			log_ovr <= stg_log_ovr;
			activate <= stg_activate;
			pid_clear <= stg_pid_clear;
			setpoint <= stg_setpoint;
			p_coef <= stg_p_coef;
			i_coef <= stg_i_coef;
			d_coef <= stg_d_coef;
			src_sel <= stg_src;
			lock_en <= stg_lock_en;
			init_en <= stg_init_en;
			out_min <= stg_min;
			out_max <= stg_max;
			out_init <= stg_init;
			multiplier <= stg_mult;
		end
	end
end

// filters size their counters on this bound
a_log_ovr_range: assert property (@(posedge clk50) disable iff (reset)
	cfg_update |=> log_ovr <= MAX_LOG_OVR);

endmodule

`default_nettype wire

//--- oversample_filter.sv
`timescale 1ns/1ps
`default_nettype none

module oversample_filter import pid_pkg::*; #(
	parameter int N_CHAN = 4,
	parameter int CHAN = 0,
	localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
	input  logic              clk50,
	input  logic              reset,
	input  logic              sample_valid,
	input  logic [W_CHAN-1:0] sample_chan,
	input  adc_t              sample_data,
	input  log_ovr_t          log_ovr,
	input  logic              activate,
	output adc_t              data,
	output logic              data_valid
);

// room for 2^MAX_LOG_OVR full scale samples
localparam int W_SUM = W_ADC + MAX_LOG_OVR;

logic [MAX_LOG_OVR-1:0] count;
logic [MAX_LOG_OVR-1:0] last_count;
logic signed [W_SUM-1:0] sum;
logic signed [W_SUM-1:0] sum_next;
logic signed [W_SUM-1:0] avg;
logic accept;
logic last;

assign accept = sample_valid && activate && (sample_chan == W_CHAN'(CHAN));

// block length minus one
assign last_count = {MAX_LOG_OVR{1'b1}} >> (MAX_LOG_OVR - log_ovr);
// >= so a ratio lowered mid block still closes it
assign last = (count >= last_count);
assign sum_next = sum + sample_data;
assign avg = sum_next >>> log_ovr;

always_ff @(posedge clk50) begin
	if (reset) begin
		count <= '0;
		sum <= '0;
		data_valid <= 1'b0;
	end else begin
		data_valid <= accept && last;
		if (!activate) begin
			count <= '0;
			sum <= '0;
		end else if (accept) begin
			if (last) begin
				count <= '0;
				sum <= '0;
			end else begin
				count <= count + 1'b1;
				sum <= sum_next;
			end
		end
	end
end

// averaged word, registered with the closing sample
always_ff @(posedge clk50) begin
	if (accept && last)
		data <= avg[W_ADC-1:0];
end

// the top level sample port must carry a real channel
a_chan_range: assert property (@(posedge clk50) disable iff (reset)
	sample_valid |-> int'(sample_chan) < N_CHAN);

endmodule

`default_nettype wire

//--- pid_core.sv
`timescale 1ns/1ps
`default_nettype none

module pid_core import pid_pkg::*; (
	input  logic  clk50,
	input  logic  reset,
	input  adc_t  data,
	input  logic  data_valid,
	input  coef_t setpoint,
	input  coef_t p_coef,
	input  coef_t i_coef,
	input  coef_t d_coef,
	input  logic  clear,
	output pid_t  pid_data,
	output logic  pid_valid
);

localparam int W_ERR = W_ADC + 1;
localparam int W_ACC = W_COEF + W_INT + 2;

////////////////////////////////////////
// error and integrator
////////////////////////////////////////

logic signed [W_ERR-1:0] err;
logic signed [W_ERR-1:0] prev_err;
logic signed [W_ERR:0] d_diff;
logic signed [W_INT-1:0] integ;
logic signed [W_INT:0] integ_sum;
logic signed [W_INT-1:0] integ_new;

assign err = setpoint - data;
assign d_diff = err - prev_err;
assign integ_sum = integ + err;

// integrator saturation
always_comb begin
	if (integ_sum > INT_MAX)
		integ_new = INT_MAX;
	else if (integ_sum < INT_MIN)
		integ_new = INT_MIN;
	else
		integ_new = integ_sum[W_INT-1:0];
end

////////////////////////////////////////
// terms, sum and output saturation
////////////////////////////////////////

logic signed [W_COEF+W_ERR-1:0] p_term;
logic signed [W_COEF+W_INT-1:0] i_term;
logic signed [W_COEF+W_ERR:0] d_term;
logic signed [W_ACC-1:0] acc;
logic signed [W_ACC-1:0] acc_shift;
pid_t out_sat;

assign p_term = p_coef * err;
// i term uses the integrator after this sample
assign i_term = i_coef * integ_new;
assign d_term = d_coef * d_diff;
assign acc = p_term + i_term + d_term;
assign acc_shift = acc >>> PID_SHIFT;

always_comb begin
	if (acc_shift > PID_MAX)
		out_sat = PID_MAX;
	else if (acc_shift < PID_MIN)
		out_sat = PID_MIN;
	else
		out_sat = acc_shift[W_PID-1:0];
end

// clear wins over a sample on the same edge, the sample still produces an output
always_ff @(posedge clk50) begin
	if (reset) begin
		integ <= '0;
		prev_err <= '0;
		pid_valid <= 1'b0;
	end else begin
		pid_valid <= data_valid;
		if (clear) begin
			integ <= '0;
			prev_err <= '0;
		end else if (data_valid) begin
			integ <= integ_new;
			prev_err <= err;
		end
	end
end

always_ff @(posedge clk50) begin
	if (data_valid)
		pid_data <= out_sat;
end

endmodule

`default_nettype wire

//--- output_preprocessor.sv
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor import pid_pkg::*; #(
	parameter type out_t = dac_word_t,
	parameter int N_CHAN = 4,
	localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
	input  logic              clk50,
	input  logic              reset,
	input  pid_t              pid_data [N_CHAN],
	input  logic [N_CHAN-1:0] pid_valid,
	input  logic [W_CHAN-1:0] src_sel,
	input  logic              lock_en,
	input  logic              init_en,
	input  bound_t            out_min,
	input  bound_t            out_max,
	input  bound_t            out_init,
	input  mult_t             multiplier,
	output out_t              out_data,
	output logic              out_valid
);

localparam int W_OUT = $bits(out_t);
localparam int W_STEP = W_MULT + 1 + W_PID;
// unsigned word plus step, with headroom for 48 bit words
localparam int W_SUM = W_BOUND + 2;

////////////////////////////////////////
// source routing
////////////////////////////////////////

pid_t sel_data;
logic sel_valid;

assign sel_data = pid_data[src_sel];
// selects past the last channel never fire
assign sel_valid = (int'(src_sel) < N_CHAN) && pid_valid[src_sel];

////////////////////////////////////////
// scale, accumulate, clamp
////////////////////////////////////////

logic signed [W_STEP-1:0] step;
logic signed [W_SUM-1:0] sum;
bound_t clamped;

// multiplier is unsigned, pid value signed
assign step = $signed({1'b0, multiplier}) * sel_data;
assign sum = $signed({1'b0, out_data}) + step;

always_comb begin
	if (sum > out_max)
		clamped = out_max;
	else if (sum < out_min)
		clamped = out_min;
	else
		clamped = sum[W_BOUND-1:0];
end

// output word doubles as the accumulator
always_ff @(posedge clk50) begin
	if (reset) begin
		out_data <= '0;
		out_valid <= 1'b0;
	end else begin
		out_valid <= 1'b0;
		if (init_en) begin
			out_data <= out_t'(out_init[W_OUT-1:0]);
		end else if (lock_en && sel_valid) begin
			out_data <= out_t'(clamped[W_OUT-1:0]);
			out_valid <= 1'b1;
		end
	end
end

// bounds come from the shared register set
a_bounds_order: assert property (@(posedge clk50) disable iff (reset)
	lock_en |-> out_min <= out_max);

endmodule

`default_nettype wire

//--- pid_controller.sv
`timescale 1ns/1ps
`default_nettype none

module pid_controller import pid_pkg::*; #(
	parameter int N_CHAN = 4,
	parameter int N_DAC = 2,
	parameter int N_DDS = 1,
	localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
	input  logic              clk50,
	input  logic              reset,
	// host register port
	input  logic              cfg_write,
	input  cfg_addr_t         cfg_addr,
	input  cfg_data_t         cfg_data,
	input  logic              cfg_update,
	// sample port
	input  logic              sample_valid,
	input  logic [W_CHAN-1:0] sample_chan,
	input  adc_t              sample_data,
	// outputs
	output dac_word_t         dac_data [N_DAC],
	output logic [N_DAC-1:0]  dac_valid,
	output freq_word_t        freq_data [N_DDS],
	output logic [N_DDS-1:0]  freq_valid
);

// dac outputs first, then frequency outputs
localparam int N_OUT = N_DAC + N_DDS;

log_ovr_t          log_ovr;
logic [N_CHAN-1:0] activate;
logic [N_CHAN-1:0] pid_clear;
coef_t             setpoint;
coef_t             p_coef;
coef_t             i_coef;
coef_t             d_coef;
logic [W_CHAN-1:0] src_sel [N_OUT];
logic [N_OUT-1:0]  lock_en;
logic [N_OUT-1:0]  init_en;
bound_t            out_min;
bound_t            out_max;
bound_t            out_init;
mult_t             multiplier;
adc_t              osf_data [N_CHAN];
logic [N_CHAN-1:0] osf_valid;
pid_t              pid_data [N_CHAN];
logic [N_CHAN-1:0] pid_valid;

////////////////////////////////////////
// decode
////////////////////////////////////////

config_regs #(.N_CHAN(N_CHAN), .N_OUT(N_OUT)) u_regs (
	.clk50(clk50), .reset(reset),
	.cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
	.cfg_update(cfg_update), .log_ovr(log_ovr), .activate(activate),
	.pid_clear(pid_clear), .setpoint(setpoint), .p_coef(p_coef),
	.i_coef(i_coef), .d_coef(d_coef), .src_sel(src_sel),
	.lock_en(lock_en), .init_en(init_en), .out_min(out_min),
	.out_max(out_max), .out_init(out_init), .multiplier(multiplier)
);

////////////////////////////////////////
// execute, filter and pid per channel
////////////////////////////////////////

for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
	oversample_filter #(.N_CHAN(N_CHAN), .CHAN(c)) u_osf (
		.clk50(clk50), .reset(reset),
		.sample_valid(sample_valid), .sample_chan(sample_chan),
		.sample_data(sample_data), .log_ovr(log_ovr),
		.activate(activate[c]), .data(osf_data[c]), .data_valid(osf_valid[c])
	);

	pid_core u_pid (
		.clk50(clk50), .reset(reset),
		.data(osf_data[c]), .data_valid(osf_valid[c]),
		.setpoint(setpoint), .p_coef(p_coef), .i_coef(i_coef), .d_coef(d_coef),
		.clear(pid_clear[c]), .pid_data(pid_data[c]), .pid_valid(pid_valid[c])
	);
end

////////////////////////////////////////
// result, one preprocessor per output
////////////////////////////////////////

for (genvar d = 0; d < N_DAC; d++) begin : g_dac
	output_preprocessor #(.out_t(dac_word_t), .N_CHAN(N_CHAN)) u_opp (
		.clk50(clk50), .reset(reset),
		.pid_data(pid_data), .pid_valid(pid_valid), .src_sel(src_sel[d]),
		.lock_en(lock_en[d]), .init_en(init_en[d]),
		.out_min(out_min), .out_max(out_max), .out_init(out_init),
		.multiplier(multiplier), .out_data(dac_data[d]), .out_valid(dac_valid[d])
	);
end

// frequency outputs sit after the dacs in the select and enable maps
for (genvar f = 0; f < N_DDS; f++) begin : g_dds
	output_preprocessor #(.out_t(freq_word_t), .N_CHAN(N_CHAN)) u_opp (
		.clk50(clk50), .reset(reset),
		.pid_data(pid_data), .pid_valid(pid_valid), .src_sel(src_sel[N_DAC+f]),
		.lock_en(lock_en[N_DAC+f]), .init_en(init_en[N_DAC+f]),
		.out_min(out_min), .out_max(out_max), .out_init(out_init),
		.multiplier(multiplier), .out_data(freq_data[f]), .out_valid(freq_valid[f])
	);
end

endmodule

`default_nettype wire

//--- tb_pid_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pid_controller import pid_pkg::*; ();

localparam int N_CHAN = 4;
localparam int N_DAC = 2;
localparam int N_DDS = 1;
localparam int N_OUT = N_DAC + N_DDS;
localparam int W_CHAN = $clog2(N_CHAN);
localparam int DRAIN_TIMEOUT = 200;
localparam longint INT_HI = 64'sd2147483647;
localparam longint INT_LO = -64'sd2147483648;

logic              clk50;
logic              reset;
logic              cfg_write;
cfg_addr_t         cfg_addr;
cfg_data_t         cfg_data;
logic              cfg_update;
logic              sample_valid;
logic [W_CHAN-1:0] sample_chan;
adc_t              sample_data;
dac_word_t         dac_data [N_DAC];
logic [N_DAC-1:0]  dac_valid;
freq_word_t        freq_data [N_DDS];
logic [N_DDS-1:0]  freq_valid;

pid_controller #(.N_CHAN(N_CHAN), .N_DAC(N_DAC), .N_DDS(N_DDS)) UUT (
	.clk50(clk50), .reset(reset),
	.cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
	.cfg_update(cfg_update),
	.sample_valid(sample_valid), .sample_chan(sample_chan),
	.sample_data(sample_data),
	.dac_data(dac_data), .dac_valid(dac_valid),
	.freq_data(freq_data), .freq_valid(freq_valid)
);

// 40 ns period
always #20 clk50 = ~clk50;

// posedge count sampled at the falling edge
int unsigned cyc = 0;
always @(posedge clk50) begin
	cyc <= cyc + 1;
end

////////////////////////////////////////
// reference model state
////////////////////////////////////////

// staged and live register map
cfg_data_t stg_reg [256];
cfg_data_t act_reg [256];
// per channel filter and pid state and per output words
longint f_sum [N_CHAN];
int     f_cnt [N_CHAN];
longint integ_m [N_CHAN];
longint perr_m [N_CHAN];
longint out_val [N_OUT];
// expected valids in due order
int unsigned exp_due [$];
int          exp_out [$];
longint      exp_val [$];

int n_dac = 0;
int n_freq = 0;
int n_valid = 0;
int n_other = 0;
logic [31:0] rng_state = 32'h5c48_e71f;

function automatic logic [31:0] xorshift32(logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] rand32();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

// low w bits as a signed value
function automatic longint sext(longint v, int w);
	return (v << (64 - w)) >>> (64 - w);
endfunction

function automatic longint rand_signed(int w);
	return sext(longint'(rand32()), w);
endfunction

function automatic longint saturate(longint v, longint lo, longint hi);
	if (v > hi)
		return hi;
	if (v < lo)
		return lo;
	return v;
endfunction

// 48 bit bound from its lo and hi halves
function automatic longint bound_val(int lo_addr);
	return sext({act_reg[lo_addr + 1][15:0], act_reg[lo_addr]}, 48);
endfunction

// dacs keep 16 bits and frequency words 48
function automatic longint out_mask(int o);
	return (o < N_DAC) ? 64'hffff : 64'hffff_ffff_ffff;
endfunction

function automatic longint pid_model(int c, longint avg);
	longint err;
	longint sum;
	err = sext(longint'(act_reg[ADDR_SETPOINT]), 16) - avg;
	integ_m[c] = saturate(integ_m[c] + err, INT_LO, INT_HI);
	sum = sext(longint'(act_reg[ADDR_P_COEF]), 16) * err
		+ sext(longint'(act_reg[ADDR_I_COEF]), 16) * integ_m[c]
		+ sext(longint'(act_reg[ADDR_D_COEF]), 16) * (err - perr_m[c]);
	perr_m[c] = err;
	return saturate(sum >>> PID_SHIFT, -64'sd32768, 64'sd32767);
endfunction

// accumulate into every locked output fed by channel c
task automatic post_output(int c, longint pid);
	longint s;
	for (int o = 0; o < N_OUT; o++) begin
		if (act_reg[ADDR_LOCK_EN][o] &&
			int'(act_reg[ADDR_SRC_BASE + o][W_CHAN-1:0]) == c) begin
			s = out_val[o] + longint'(act_reg[ADDR_MULT][7:0]) * pid;
			s = saturate(s, bound_val(ADDR_MIN_LO), bound_val(ADDR_MAX_LO));
			out_val[o] = s & out_mask(o);
			// three register stages from sample to output
			exp_due.push_back(cyc + 3);
			exp_out.push_back(o);
			exp_val.push_back(out_val[o]);
		end
	end
endtask

task automatic model_sample(int c, longint d);
	int l;
	l = int'(act_reg[ADDR_LOG_OVR][2:0]);
	if (act_reg[ADDR_ACTIVATE][c]) begin
		f_sum[c] += d;
		f_cnt[c]++;
		if (f_cnt[c] == (1 << l)) begin
			post_output(c, pid_model(c, f_sum[c] >>> l));
			f_sum[c] = 0;
			f_cnt[c] = 0;
		end
	end
endtask

////////////////////////////////////////
// checks
////////////////////////////////////////

task automatic check_dac(int idx, dac_word_t got, dac_word_t exp);
	if (got !== exp) begin
		n_dac++;
		$display("error dac_data[%0d] got 0x%h expected 0x%h at cycle %0d",
			idx, got, exp, cyc);
	end
endtask

task automatic check_freq(int idx, freq_word_t got, freq_word_t exp);
	if (got !== exp) begin
		n_freq++;
		$display("error freq_data[%0d] got 0x%h expected 0x%h at cycle %0d",
			idx, got, exp, cyc);
	end
endtask

task automatic check_valid(string name, int idx, logic got, logic exp);
	if (got !== exp) begin
		n_valid++;
		$display("error %s[%0d] got 0x%h expected 0x%h at cycle %0d",
			name, idx, got, exp, cyc);
	end
endtask

// valids compared every cycle and data on a pulse
task automatic check_outputs();
	logic [N_OUT-1:0] hit;
	longint word [N_OUT];
	hit = '0;
	for (int o = 0; o < N_OUT; o++)
		word[o] = 0;
	while (exp_due.size() > 0 && exp_due[0] <= cyc) begin
		hit[exp_out[0]] = 1'b1;
		word[exp_out[0]] = exp_val[0];
		void'(exp_due.pop_front());
		void'(exp_out.pop_front());
		void'(exp_val.pop_front());
	end
	for (int d = 0; d < N_DAC; d++) begin
		check_valid("dac_valid", d, dac_valid[d], hit[d]);
		if (hit[d])
			check_dac(d, dac_data[d], dac_word_t'(word[d]));
	end
	for (int f = 0; f < N_DDS; f++) begin
		check_valid("freq_valid", f, freq_valid[f], hit[N_DAC + f]);
		if (hit[N_DAC + f])
			check_freq(f, freq_data[f], freq_word_t'(word[N_DAC + f]));
	end
endtask

// held words against the model between pulses
task automatic check_held();
	for (int d = 0; d < N_DAC; d++)
		check_dac(d, dac_data[d], dac_word_t'(out_val[d]));
	for (int f = 0; f < N_DDS; f++)
		check_freq(f, freq_data[f], freq_word_t'(out_val[N_DAC + f]));
endtask

task automatic finish_run();
	$display("totals: dac errors %0d, freq errors %0d, valid errors %0d, other failures %0d",
		n_dac, n_freq, n_valid, n_other);
	if (n_dac + n_freq + n_valid + n_other == 0) begin
		$display("Simulation passed");
	end else begin
		$display("Simulation failed");
	end
	$finish;
endtask

////////////////////////////////////////
// stimulus
////////////////////////////////////////

// check at the falling edge and then drop strobes
task automatic next_cycle();
	@(negedge clk50);
	check_outputs();
	cfg_write = 1'b0;
	cfg_update = 1'b0;
	sample_valid = 1'b0;
endtask

task automatic drain();
	int waited;
	waited = 0;
	while (exp_due.size() > 0 && waited < DRAIN_TIMEOUT) begin
		next_cycle();
		waited++;
	end
	if (exp_due.size() > 0) begin
		n_other++;
		$display("timeout while waiting for the expected output valids");
		exp_due.delete();
		exp_out.delete();
		exp_val.delete();
	end else begin
		// unrouted blocks still in flight
		repeat (4) next_cycle();
	end
endtask

task automatic write_reg(int addr, longint data);
	next_cycle();
	cfg_write = 1'b1;
	cfg_addr = cfg_addr_t'(addr);
	cfg_data = cfg_data_t'(data);
	stg_reg[addr] = cfg_data_t'(data);
endtask

// update strobe with the model moving on the same cycle
task automatic commit();
	drain();
	next_cycle();
	cfg_update = 1'b1;
	act_reg = stg_reg;
	for (int c = 0; c < N_CHAN; c++) begin
		if (act_reg[ADDR_PID_CLEAR][c]) begin
			integ_m[c] = 0;
			perr_m[c] = 0;
		end
		if (!act_reg[ADDR_ACTIVATE][c]) begin
			f_sum[c] = 0;
			f_cnt[c] = 0;
		end
	end
	for (int o = 0; o < N_OUT; o++) begin
		if (act_reg[ADDR_INIT_EN][o])
			out_val[o] = bound_val(ADDR_INIT_LO) & out_mask(o);
	end
endtask

task automatic clear_masks();
	write_reg(ADDR_PID_CLEAR, 0);
	write_reg(ADDR_INIT_EN, 0);
endtask

task automatic set_bounds(longint lo, longint hi, longint init);
	write_reg(ADDR_MIN_LO, lo[31:0]);
	write_reg(ADDR_MIN_HI, lo[47:32]);
	write_reg(ADDR_MAX_LO, hi[31:0]);
	write_reg(ADDR_MAX_HI, hi[47:32]);
	write_reg(ADDR_INIT_LO, init[31:0]);
	write_reg(ADDR_INIT_HI, init[47:32]);
endtask

task automatic set_routes();
	for (int o = 0; o < N_OUT; o++)
		write_reg(ADDR_SRC_BASE + o, rand32() % N_CHAN);
endtask

// small coefficients that still let the integrator saturate the pid
task automatic random_pid_config();
	write_reg(ADDR_SETPOINT, rand_signed(12));
	write_reg(ADDR_P_COEF, rand_signed(9));
	write_reg(ADDR_I_COEF, rand_signed(5));
	write_reg(ADDR_D_COEF, rand_signed(7));
	write_reg(ADDR_MULT, rand32() % 16);
	set_routes();
endtask

// random channels with about one idle cycle in four
task automatic stream(int n);
	logic [31:0] r;
	int c;
	longint d;
	for (int i = 0; i < n; i++) begin
		r = rand32();
		if (r[31:30] == 2'b00) begin
			next_cycle();
		end else begin
			c = int'(r % N_CHAN);
			d = sext(longint'(r >> 8), 13);
			next_cycle();
			sample_valid = 1'b1;
			sample_chan = c[W_CHAN-1:0];
			sample_data = adc_t'(d);
			model_sample(c, d);
		end
	end
endtask

initial begin
	longint base;
	clk50 = 1'b0;
	reset = 1'b1;
	cfg_write = 1'b0;
	cfg_addr = '0;
	cfg_data = '0;
	cfg_update = 1'b0;
	sample_valid = 1'b0;
	sample_chan = '0;
	sample_data = '0;
	for (int a = 0; a < 256; a++) begin
		stg_reg[a] = '0;
		act_reg[a] = '0;
	end
	for (int c = 0; c < N_CHAN; c++) begin
		f_sum[c] = 0;
		f_cnt[c] = 0;
		integ_m[c] = 0;
		perr_m[c] = 0;
	end
	for (int o = 0; o < N_OUT; o++)
		out_val[o] = 0;
	repeat (8) @(posedge clk50);
	@(negedge clk50);
	reset = 1'b0;

	// nothing committed yet so samples stay silent
	stream(40);
	check_held();

	// one sample per block with every channel live
	set_bounds(0, 64'hffff, 64'h8000);
	write_reg(ADDR_LOG_OVR, 0);
	write_reg(ADDR_ACTIVATE, (1 << N_CHAN) - 1);
	write_reg(ADDR_LOCK_EN, (1 << N_OUT) - 1);
	write_reg(ADDR_INIT_EN, (1 << N_OUT) - 1);
	write_reg(ADDR_PID_CLEAR, (1 << N_CHAN) - 1);
	random_pid_config();
	commit();
	clear_masks();
	stream(80);

	// block averages with the filters flushed between ratios
	for (int round = 0; round < 6; round++) begin
		write_reg(ADDR_ACTIVATE, 0);
		commit();
		write_reg(ADDR_LOG_OVR, 1 + rand32() % MAX_LOG_OVR);
		write_reg(ADDR_ACTIVATE, rand32() % (1 << N_CHAN));
		random_pid_config();
		commit();
		stream(120);
	end

	// partial blocks flushed before the ratio drops back to one
	write_reg(ADDR_ACTIVATE, 0);
	commit();

	// tight bounds far above the dac range
	base = longint'(rand32()) << 14;
	set_bounds(base - rand32() % 4096, base + rand32() % 4096, base);
	write_reg(ADDR_LOG_OVR, 0);
	write_reg(ADDR_ACTIVATE, (1 << N_CHAN) - 1);
	write_reg(ADDR_INIT_EN, (1 << N_OUT) - 1);
	// nonzero scale so the steps reach the bounds
	write_reg(ADDR_MULT, 1 + rand32() % 15);
	commit();
	clear_masks();
	drain();
	check_held();
	stream(60);
	// tight bounds inside the dac range
	set_bounds(64'h7f00, 64'h8100, 64'h8000);
	write_reg(ADDR_INIT_EN, (1 << N_OUT) - 1);
	commit();
	clear_masks();
	stream(60);

	// staged routes only so the old routing holds
	set_routes();
	write_reg(8'h7f, rand32());
	stream(60);
	commit();
	stream(60);

	// integrator clear and output reload
	write_reg(ADDR_PID_CLEAR, rand32() % (1 << N_CHAN));
	write_reg(ADDR_INIT_EN, rand32() % (1 << N_OUT));
	commit();
	clear_masks();
	drain();
	check_held();
	stream(60);

	drain();
	check_held();
	finish_run();
end

endmodule

`default_nettype wire

//--- project.f
pid_pkg.sv
config_regs.sv
oversample_filter.sv
pid_core.sv
output_preprocessor.sv
pid_controller.sv
tb_pid_controller.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0 --assert -Wno-fatal
TOP       = tb_pid_controller
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
